// File: hdl/link_pkg.sv
/* link request field definitions */

package link_pkg;

  // word address of a link request; the MSB selects tag space
  localparam int LINK_ADDR_W = 12;

  // payload word and its byte enables
  localparam int DATA_W = 32;
  localparam int MASK_W = 4;

  // one mesh coordinate, x or y
  localparam int CORD_W = 4;

  // incoming request buffer in the endpoint
  localparam int FIFO_ELS = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_ELS);

endpackage

// File: hdl/cache_pkg.sv
/* cache storage geometry and packet types */

package cache_pkg;

  // storage geometry
  localparam int SETS = 8;
  localparam int WAYS = 2;
  localparam int BLOCK_WORDS = 4;
  localparam int TAG_ENTRIES = SETS * WAYS;
  localparam int DATA_WORDS = 64;

  // byte address layout of a cache packet
  localparam int BYTE_OFFSET_W = $clog2(link_pkg::MASK_W);
  localparam int WORD_OFFSET_W = $clog2(BLOCK_WORDS);
  localparam int TAG_IDX_W = $clog2(TAG_ENTRIES);
  localparam int DATA_IDX_W = $clog2(DATA_WORDS);
  localparam int CACHE_ADDR_W = link_pkg::LINK_ADDR_W - 1 + BYTE_OFFSET_W;

  typedef enum logic [1:0] {
    LM,
    SM,
    TAGST,
    TAGLA
  } cache_op_e;

  typedef struct packed {
    cache_op_e                   opcode;
    logic [CACHE_ADDR_W-1:0]     addr;
    logic [link_pkg::DATA_W-1:0] data;
    logic [link_pkg::MASK_W-1:0] mask;
  } cache_pkt_s;

  // link adapter sequencing
  typedef enum logic [1:0] {
    RESET,
    CLEAR_TAG,
    READY
  } adapter_state_e;

endpackage

// File: hdl/ep_req_if.sv
/* endpoint to adapter request path */
`timescale 1ns/1ps

interface ep_req_if;
  import link_pkg::*;

  // head of the request FIFO, valid while not empty
  logic                   req_v;
  logic                   req_we;
  logic [LINK_ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0]      req_data;
  logic [MASK_W-1:0]      req_mask;

  // pops the head in the same cycle
  logic                   req_yumi;

  // one-cycle return strobe
  logic                   ret_v;
  logic [DATA_W-1:0]      ret_data;

  modport endpoint (
    output req_v, req_we, req_addr, req_data, req_mask,
    input  req_yumi, ret_v, ret_data
  );

  modport adapter (
    input  req_v, req_we, req_addr, req_data, req_mask,
    output req_yumi, ret_v, ret_data
  );

endinterface

// File: hdl/cache_bus_if.sv
/* adapter to storage packet bus */
`timescale 1ns/1ps

interface cache_bus_if;
  import link_pkg::*;
  import cache_pkg::*;

  // packet channel, taken when pkt_v and pkt_ready are both high
  cache_pkt_s        pkt;
  logic              pkt_v;
  logic              pkt_ready;

  // response channel, held until rsp_yumi
  logic              rsp_v;
  logic [DATA_W-1:0] rsp_data;
  logic              rsp_yumi;

  modport master (
    output pkt, pkt_v, rsp_yumi,
    input  pkt_ready, rsp_v, rsp_data
  );

  modport slave (
    input  pkt, pkt_v, rsp_yumi,
    output pkt_ready, rsp_v, rsp_data
  );

endinterface

// File: hdl/link_endpoint.sv
/* link endpoint request buffer */
`timescale 1ns/1ps

module link_endpoint (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [link_pkg::CORD_W-1:0]    my_x_i,
  input  logic [link_pkg::CORD_W-1:0]    my_y_i,
  input  logic                           req_v_i,
  input  logic                           req_we_i,
  input  logic [link_pkg::LINK_ADDR_W-1:0] req_addr_i,
  input  logic [link_pkg::DATA_W-1:0]    req_data_i,
  input  logic [link_pkg::MASK_W-1:0]    req_mask_i,
  input  logic [link_pkg::CORD_W-1:0]    req_dst_x_i,
  input  logic [link_pkg::CORD_W-1:0]    req_dst_y_i,
  output logic                           req_ready_o,
  output logic                           resp_v_o,
  output logic [link_pkg::DATA_W-1:0]    resp_data_o,
  ep_req_if.endpoint                     ep
);
  import link_pkg::*;

  logic                   we_mem   [FIFO_ELS];
  logic [LINK_ADDR_W-1:0] addr_mem [FIFO_ELS];
  logic [DATA_W-1:0]      data_mem [FIFO_ELS];
  logic [MASK_W-1:0]      mask_mem [FIFO_ELS];

  logic [FIFO_PTR_W-1:0] wr_ptr_r;
  logic [FIFO_PTR_W-1:0] rd_ptr_r;
  logic [FIFO_PTR_W:0]   count_r;

  logic for_me;
  logic push;
  logic pop;

  logic              resp_v_r;
  logic [DATA_W-1:0] resp_data_r;

  // accepted whenever there is room, kept only if addressed to this tile
  assign req_ready_o = (count_r != FIFO_ELS);
  assign for_me = (req_dst_x_i == my_x_i) && (req_dst_y_i == my_y_i);
  assign push = req_v_i & req_ready_o & for_me;
  assign pop = ep.req_yumi;

  // head of the FIFO
  assign ep.req_v    = (count_r != '0);
  assign ep.req_we   = we_mem[rd_ptr_r];
  assign ep.req_addr = addr_mem[rd_ptr_r];
  assign ep.req_data = data_mem[rd_ptr_r];
  assign ep.req_mask = mask_mem[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (push) begin
      we_mem[wr_ptr_r]   <= req_we_i;
      addr_mem[wr_ptr_r] <= req_addr_i;
      data_mem[wr_ptr_r] <= req_data_i;
      mask_mem[wr_ptr_r] <= req_mask_i;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // response goes out one cycle after the return strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= ep.ret_v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ep.ret_v) begin
      resp_data_r <= ep.ret_data;
    end
  end

  assign resp_v_o = resp_v_r;
  assign resp_data_o = resp_data_r;

endmodule

// File: hdl/link_to_cache.sv
/* link request to cache packet adapter */
`timescale 1ns/1ps

module link_to_cache (
  input  logic        clk_i,
  input  logic        reset_i,
  output logic        init_done_o,
  ep_req_if.adapter   ep,
  cache_bus_if.master cb
);
  import link_pkg::*;
  import cache_pkg::*;

  adapter_state_e state_r;
  adapter_state_e state_n;

  // one extra bit so the counters can reach TAG_ENTRIES
  logic [TAG_IDX_W:0] sent_r;
  logic [TAG_IDX_W:0] sent_n;
  logic [TAG_IDX_W:0] rcvd_r;
  logic [TAG_IDX_W:0] rcvd_n;

  cache_pkt_s pkt;

  assign cb.pkt = pkt;
  assign ep.ret_data = cb.rsp_data;
  assign init_done_o = (state_r == READY);

  always_comb begin
    state_n = state_r;
    sent_n = sent_r;
    rcvd_n = rcvd_r;

    pkt.opcode = TAGST;
    pkt.addr = '0;
    pkt.data = {DATA_W{1'b0}};
    pkt.mask = {MASK_W{1'b1}};

    cb.pkt_v = 1'b0;
    cb.rsp_yumi = 1'b0;
    ep.req_yumi = 1'b0;
    ep.ret_v = 1'b0;

    case (state_r)
      RESET: begin
        state_n = CLEAR_TAG;
      end

      CLEAR_TAG: begin
        // zero every tag entry, index sits above word and byte offsets
        cb.pkt_v = (sent_r != TAG_ENTRIES);
        pkt.addr = {
          {(CACHE_ADDR_W-TAG_IDX_W-WORD_OFFSET_W-BYTE_OFFSET_W){1'b0}},
          sent_r[TAG_IDX_W-1:0],
          {(WORD_OFFSET_W+BYTE_OFFSET_W){1'b0}}
        };

        // clear responses are absorbed here
        cb.rsp_yumi = cb.rsp_v;

        if (cb.pkt_v && cb.pkt_ready) begin
          sent_n = sent_r + 1'b1;
        end
        if (cb.rsp_v) begin
          rcvd_n = rcvd_r + 1'b1;
        end

        if ((sent_r == TAG_ENTRIES) && (rcvd_r == TAG_ENTRIES)) begin
          state_n = READY;
        end
      end

      READY: begin
        cb.pkt_v = ep.req_v;
        ep.req_yumi = ep.req_v & cb.pkt_ready;

        // MSB set means tag space
        if (ep.req_addr[LINK_ADDR_W-1]) begin
          pkt.opcode = ep.req_we ? TAGST : TAGLA;
        end else begin
          pkt.opcode = ep.req_we ? SM : LM;
        end
        pkt.addr = {ep.req_addr[LINK_ADDR_W-2:0], {BYTE_OFFSET_W{1'b0}}};
        pkt.data = ep.req_data;
        pkt.mask = ep.req_mask;

        cb.rsp_yumi = cb.rsp_v;
        ep.ret_v = cb.rsp_v;
      end

      default: begin
        state_n = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RESET;
      sent_r  <= '0;
      rcvd_r  <= '0;
    end else begin
      state_r <= state_n;
      sent_r  <= sent_n;
      rcvd_r  <= rcvd_n;
    end
  end

endmodule

// File: hdl/cache_array.sv
/* tag and data storage */
`timescale 1ns/1ps

module cache_array (
  input  logic       clk_i,
  input  logic       reset_i,
  cache_bus_if.slave cb
);
  import link_pkg::*;
  import cache_pkg::*;

  logic [DATA_W-1:0] tag_mem  [TAG_ENTRIES];
  logic [DATA_W-1:0] data_mem [DATA_WORDS];

  logic [TAG_IDX_W-1:0]  tag_idx;
  logic [DATA_IDX_W-1:0] data_idx;
  logic                  take;

  logic              rsp_v_r;
  logic [DATA_W-1:0] rsp_data_r;

  // data index is the word address modulo DATA_WORDS
  assign data_idx = cb.pkt.addr[BYTE_OFFSET_W +: DATA_IDX_W];
  assign tag_idx = cb.pkt.addr[BYTE_OFFSET_W+WORD_OFFSET_W +: TAG_IDX_W];

  // a pending response blocks new packets unless it is being yumied
  assign cb.pkt_ready = ~rsp_v_r | cb.rsp_yumi;
  assign take = cb.pkt_v & cb.pkt_ready;

  assign cb.rsp_v = rsp_v_r;
  assign cb.rsp_data = rsp_data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v_r <= 1'b0;
    end else if (take) begin
      rsp_v_r <= 1'b1;
    end else if (cb.rsp_yumi) begin
      rsp_v_r <= 1'b0;
    end
  end

  // loads see the contents before this cycle's write
  always_ff @(posedge clk_i) begin
    if (take) begin
      case (cb.pkt.opcode)
        LM:      rsp_data_r <= data_mem[data_idx];
        TAGLA:   rsp_data_r <= tag_mem[tag_idx];
        default: rsp_data_r <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && cb.pkt.opcode == TAGST) begin
      tag_mem[tag_idx] <= cb.pkt.data;
    end
  end

  // data words read back as zero until written
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int w = 0; w < DATA_WORDS; w++) begin
        data_mem[w] <= '0;
      end
    end else if (take && cb.pkt.opcode == SM) begin
      for (int b = 0; b < MASK_W; b++) begin
        if (cb.pkt.mask[b]) begin
          data_mem[data_idx][8*b +: 8] <= cb.pkt.data[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: hdl/link_cache_top.sv
/* tile memory port top level */
`timescale 1ns/1ps

module link_cache_top (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic [link_pkg::CORD_W-1:0]      my_x_i,
  input  logic [link_pkg::CORD_W-1:0]      my_y_i,
  input  logic                             req_v_i,
  input  logic                             req_we_i,
  input  logic [link_pkg::LINK_ADDR_W-1:0] req_addr_i,
  input  logic [link_pkg::DATA_W-1:0]      req_data_i,
  input  logic [link_pkg::MASK_W-1:0]      req_mask_i,
  input  logic [link_pkg::CORD_W-1:0]      req_dst_x_i,
  input  logic [link_pkg::CORD_W-1:0]      req_dst_y_i,
  output logic                             req_ready_o,
  output logic                             resp_v_o,
  output logic [link_pkg::DATA_W-1:0]      resp_data_o,
  output logic                             init_done_o
);

  ep_req_if    ep_if ();
  cache_bus_if cb_if ();

  link_endpoint u_endpoint (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .req_v_i     (req_v_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_mask_i  (req_mask_i),
    .req_dst_x_i (req_dst_x_i),
    .req_dst_y_i (req_dst_y_i),
    .req_ready_o (req_ready_o),
    .resp_v_o    (resp_v_o),
    .resp_data_o (resp_data_o),
    .ep          (ep_if.endpoint)
  );

  link_to_cache u_adapter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .init_done_o (init_done_o),
    .ep          (ep_if.adapter),
    .cb          (cb_if.master)
  );

  cache_array u_array (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cb      (cb_if.slave)
  );

endmodule

// File: testbench/link_cache_checker.sv
/* tile port protocol checks */
`timescale 1ns/1ps

module link_cache_checker (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic [link_pkg::CORD_W-1:0] my_x_i,
  input logic [link_pkg::CORD_W-1:0] my_y_i,
  input logic [link_pkg::CORD_W-1:0] req_dst_x_i,
  input logic [link_pkg::CORD_W-1:0] req_dst_y_i,
  input logic                        req_v_i,
  input logic                        req_ready_o,
  input logic                        resp_v_o,
  input logic                        init_done_o
);
  import link_pkg::*;

  localparam int INIT_LIMIT = 24;

  logic [5:0] since_reset_r;
  logic [7:0] outstanding_r;
  logic       accept_for_me;

  // bumped by every failing assertion below
  int fail_count = 0;

  assign accept_for_me = req_v_i & req_ready_o &
                         (req_dst_x_i == my_x_i) & (req_dst_y_i == my_y_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      since_reset_r <= '0;
    end else if (since_reset_r != 6'h3f) begin
      since_reset_r <= since_reset_r + 6'd1;
    end
  end

  // requests kept by the endpoint minus responses seen so far
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_r <= '0;
    end else begin
      outstanding_r <= outstanding_r + {7'd0, accept_for_me} - {7'd0, resp_v_o};
    end
  end

  resp_after_init: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o |-> init_done_o)
    else begin
      fail_count++;
      $error("response strobe seen before tag clearing finished");
    end

  init_in_time: assert property (@(posedge clk_i) disable iff (reset_i)
    (since_reset_r >= INIT_LIMIT) |-> init_done_o)
    else begin
      fail_count++;
      $error("init_done_o did not rise within %0d cycles of reset", INIT_LIMIT);
    end

  ready_low_only_full: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_ready_o |-> (outstanding_r >= FIFO_ELS))
    else begin
      fail_count++;
      $error("req_ready_o low with fewer than %0d requests outstanding", FIFO_ELS);
    end

  // nothing leaves the FIFO before init, so kept requests are all still in it
  full_before_init: assert property (@(posedge clk_i) disable iff (reset_i)
    (!init_done_o && (outstanding_r >= FIFO_ELS)) |-> !req_ready_o)
    else begin
      fail_count++;
      $error("req_ready_o stayed high with a full FIFO during tag clearing");
    end

endmodule

bind link_cache_top link_cache_checker u_checker (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .my_x_i      (my_x_i),
  .my_y_i      (my_y_i),
  .req_dst_x_i (req_dst_x_i),
  .req_dst_y_i (req_dst_y_i),
  .req_v_i     (req_v_i),
  .req_ready_o (req_ready_o),
  .resp_v_o    (resp_v_o),
  .init_done_o (init_done_o)
);

// File: testbench/link_cache_tb.sv
/* tile memory port testbench */
`timescale 1ns/1ps

module link_cache_tb;
  import link_pkg::*;
  import cache_pkg::*;

  localparam int RESET_CYCLES = 4;
  localparam int CLEAR_CYCLES = 24;
  localparam int N_DATA = 20;
  localparam int N_TAG = 8;
  localparam int N_FOREIGN = 8;
  localparam int TOTAL_REQS = 3 * TAG_ENTRIES + 2 * N_DATA + 2 * N_TAG + 8 + 2 * N_FOREIGN;
  localparam logic [CORD_W-1:0] MY_X = 4'd3;
  localparam logic [CORD_W-1:0] MY_Y = 4'd5;

  logic                   clk_i;
  logic                   reset_i;
  logic [CORD_W-1:0]      my_x_i;
  logic [CORD_W-1:0]      my_y_i;
  logic                   req_v_i;
  logic                   req_we_i;
  logic [LINK_ADDR_W-1:0] req_addr_i;
  logic [DATA_W-1:0]      req_data_i;
  logic [MASK_W-1:0]      req_mask_i;
  logic [CORD_W-1:0]      req_dst_x_i;
  logic [CORD_W-1:0]      req_dst_y_i;
  logic                   req_ready_o;
  logic                   resp_v_o;
  logic [DATA_W-1:0]      resp_data_o;
  logic                   init_done_o;

  // reference model
  logic [DATA_W-1:0] data_model [DATA_WORDS];
  logic [DATA_W-1:0] tag_model  [TAG_ENTRIES];
  logic [DATA_W-1:0] exp_q [$];
  string             name_q [$];

  link_cache_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // one request; miss bit 0 moves x and bit 1 moves y off this tile
  task automatic send_req(input string test, input logic we,
                          input logic [LINK_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input logic [MASK_W-1:0] mask, input logic [1:0] miss);
    logic [DATA_W-1:0] expected;
    int unsigned       word;
    int unsigned       entry;
    expected = '0;
    word = addr % DATA_WORDS;
    entry = (addr >> 2) % TAG_ENTRIES;
    @(negedge clk_i);
    req_v_i = 1'b1;
    req_we_i = we;
    req_addr_i = addr;
    req_data_i = data;
    req_mask_i = mask;
    req_dst_x_i = miss[0] ? my_x_i + 4'd1 : my_x_i;
    req_dst_y_i = miss[1] ? my_y_i + 4'd1 : my_y_i;
    while (!req_ready_o) @(negedge clk_i);
    // taken at the coming rising edge
    if (miss == 2'b00) begin
      if (addr[LINK_ADDR_W-1]) begin
        if (we) tag_model[entry] = data;
        else expected = tag_model[entry];
      end else if (we) begin
        for (int b = 0; b < MASK_W; b++) begin
          if (mask[b]) data_model[word][8*b +: 8] = data[8*b +: 8];
        end
      end else begin
        expected = data_model[word];
      end
      exp_q.push_back(expected);
      name_q.push_back(test);
    end
  endtask

  // reset clears data words, tags are zeroed by the clear sequence
  task automatic apply_reset();
    reset_i = 1'b1;
    req_v_i = 1'b0;
    for (int w = 0; w < DATA_WORDS; w++) data_model[w] = '0;
    for (int e = 0; e < TAG_ENTRIES; e++) tag_model[e] = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
  endtask

  task automatic read_all_tags(input string test);
    for (int e = 0; e < TAG_ENTRIES; e++) begin
      send_req(test, 1'b0, {1'b1, 5'd0, 4'(e), 2'b00}, '0, 4'hf, 2'b00);
    end
  endtask

  task automatic wait_for_responses();
    @(negedge clk_i);
    req_v_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (8) @(negedge clk_i);
  endtask

  always @(negedge clk_i) begin
    assert (u_dut.u_checker.fail_count == 0) else begin
      $display("protocol assertion in the checker failed");
      $display("Result: FAILED");
      $fatal(1);
    end
    if (!reset_i && resp_v_o) begin
      assert (exp_q.size() > 0) else begin
        $display("response %h arrived with no request outstanding", resp_data_o);
        $display("Result: FAILED");
        $fatal(1);
      end
      assert (resp_data_o == exp_q[0]) else begin
        $display("MISMATCH test %s expected %h actual %h", name_q[0], exp_q[0], resp_data_o);
        $display("Result: FAILED");
        $fatal(1);
      end
      void'(exp_q.pop_front());
      void'(name_q.pop_front());
    end
  end

  initial begin
    repeat (2 * (RESET_CYCLES + CLEAR_CYCLES) + TOTAL_REQS * 10) @(posedge clk_i);
    $display("timeout: responses did not all arrive in time");
    $display("Result: FAILED");
    $fatal(1);
  end

  initial begin
    logic [3:0]  entry;
    logic [31:0] value;
    logic [11:0] addr;
    void'($urandom(32'he8ad_a9e8));
    reset_i = 1'b1;
    my_x_i = MY_X;
    my_y_i = MY_Y;
    req_v_i = 1'b0;
    req_we_i = 1'b0;
    req_addr_i = '0;
    req_data_i = '0;
    req_mask_i = '0;
    req_dst_x_i = MY_X;
    req_dst_y_i = MY_Y;
    apply_reset();

    // issued while clearing runs, so these also fill the FIFO
    read_all_tags("tag_clear");

    // few distinct words so partial writes pile up
    for (int i = 0; i < N_DATA; i++) begin
      addr = {1'b0, 5'($urandom), 6'($urandom_range(0, 7))};
      send_req("data_rw", 1'b1, addr, $urandom, 4'($urandom), 2'b00);
      send_req("data_rw", 1'b0, addr, '0, 4'hf, 2'b00);
    end

    for (int i = 0; i < N_TAG; i++) begin
      entry = 4'($urandom_range(0, TAG_ENTRIES - 1));
      value = $urandom;
      send_req("tag_rw", 1'b1, {1'b1, 5'd0, entry, 2'b00}, value, 4'hf, 2'b00);
      send_req("tag_rw", 1'b0, {1'b1, 5'd0, entry, 2'b00}, '0, 4'hf, 2'b00);
    end
    for (int w = 0; w < 8; w++) begin
      send_req("tag_rw", 1'b0, 12'(w), '0, 4'hf, 2'b00);
    end

    for (int w = 0; w < N_FOREIGN; w++) begin
      send_req("foreign", 1'b1, 12'(w), $urandom, 4'hf, (w % 2 == 0) ? 2'b01 : 2'b10);
    end
    for (int w = 0; w < N_FOREIGN; w++) begin
      send_req("foreign", 1'b0, 12'(w), '0, 4'hf, 2'b00);
    end

    // every entry nonzero so the next clear has something to erase
    for (int e = 0; e < TAG_ENTRIES; e++) begin
      send_req("tag_fill", 1'b1, {1'b1, 5'd0, 4'(e), 2'b00}, $urandom | 32'h1, 4'hf, 2'b00);
    end
    wait_for_responses();

    apply_reset();
    read_all_tags("tag_reclear");
    wait_for_responses();

    if (u_dut.u_checker.fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1);
    end
  end

endmodule

// File: link_cache.f
hdl/link_pkg.sv
hdl/cache_pkg.sv
hdl/ep_req_if.sv
hdl/cache_bus_if.sv
hdl/link_endpoint.sv
hdl/link_to_cache.sv
hdl/cache_array.sv
hdl/link_cache_top.sv
testbench/link_cache_checker.sv
testbench/link_cache_tb.sv

// File: run_verilator.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module link_cache_tb -f link_cache.f

if ! output="$(./obj_dir/Vlink_cache_tb +verilator+error+limit+100 2>&1)"; then
  echo "$output"
  exit 1
fi
echo "$output"
grep -q "^Result: PASSED$" <<< "$output"
